// File: common/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;

    // major opcodes of the supported RV32I subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        // lui forwards the immediate unchanged
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT
    } cmp_op_t;

    typedef enum logic {
        SRC2_REG,
        SRC2_IMM
    } src2_sel_t;

    // write-back source, none for stores and branches
    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_MEM,
        WB_PC_NEXT
    } wb_sel_t;

endpackage

// File: rtl/rv_fetch.sv
module rv_fetch #(
    parameter rv_pkg::data_t BOOT_ADDR = '0
) (
    input  logic          clk,
    input  logic          arst_n_i,
    input  logic          hold_i,
    input  logic          redirect_i,
    input  rv_pkg::data_t target_i,
    output rv_pkg::data_t instr_addr_o,
    input  rv_pkg::data_t instr_rdata_i,
    output logic          fd_valid_o,
    output rv_pkg::data_t fd_instr_o,
    output rv_pkg::data_t fd_pc_o
);

    rv_pkg::data_t pc_q;

    assign instr_addr_o = pc_q;

    // a redirect stays asserted during hold, so it is taken on the first free edge
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= BOOT_ADDR;
            fd_valid_o <= 1'b0;
        end else if (!hold_i) begin
            pc_q       <= redirect_i ? target_i : pc_q + 32'd4;
            fd_valid_o <= !redirect_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            fd_instr_o <= instr_rdata_i;
            fd_pc_o    <= pc_q;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        pc_q[1:0] == 2'b00)
        else $error("fetch: misaligned pc %h", pc_q);

endmodule

// File: rtl/decode/rv_decode.sv
module rv_decode (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              hold_i,
    input  logic              flush_i,
    input  logic              fd_valid_i,
    input  rv_pkg::data_t     fd_instr_i,
    input  rv_pkg::data_t     fd_pc_i,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o,
    input  rv_pkg::data_t     rs1_data_i,
    input  rv_pkg::data_t     rs2_data_i,
    output logic              de_valid_o,
    output rv_pkg::data_t     de_pc_o,
    output rv_pkg::reg_addr_t de_rs1_o,
    output rv_pkg::reg_addr_t de_rs2_o,
    output rv_pkg::data_t     de_rs1_data_o,
    output rv_pkg::data_t     de_rs2_data_o,
    output rv_pkg::data_t     de_imm_o,
    output rv_pkg::reg_addr_t de_rd_o,
    output rv_pkg::alu_op_t   de_alu_op_o,
    output rv_pkg::src2_sel_t de_src2_sel_o,
    output rv_pkg::cmp_op_t   de_cmp_op_o,
    output logic              de_branch_o,
    output logic              de_jump_o,
    output logic              de_mem_we_o,
    output rv_pkg::wb_sel_t   de_wb_sel_o
);

    rv_pkg::opcode_t   opcode;
    logic [2:0]        funct3;
    logic              funct7_alt;
    rv_pkg::data_t     imm;
    rv_pkg::alu_op_t   alu_op;
    rv_pkg::src2_sel_t src2_sel;
    rv_pkg::cmp_op_t   cmp_op;
    logic              branch;
    logic              jump;
    logic              mem_we;
    rv_pkg::wb_sel_t   wb_sel;
    logic              op_known;

    // funct3 mapping shared by register and immediate forms
    function automatic rv_pkg::alu_op_t alu_decode(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode     = fd_instr_i[6:0];
    assign funct3     = fd_instr_i[14:12];
    assign funct7_alt = fd_instr_i[30];
    assign rs1_o      = fd_instr_i[19:15];
    assign rs2_o      = fd_instr_i[24:20];

    always_comb begin
        op_known = 1'b1;
        imm      = {{20{fd_instr_i[31]}}, fd_instr_i[31:20]};
        alu_op   = rv_pkg::ALU_ADD;
        src2_sel = rv_pkg::SRC2_IMM;
        cmp_op   = rv_pkg::CMP_EQ;
        branch   = 1'b0;
        jump     = 1'b0;
        mem_we   = 1'b0;
        wb_sel   = rv_pkg::WB_ALU;
        case (opcode)
            rv_pkg::OPC_OP: begin
                src2_sel = rv_pkg::SRC2_REG;
                alu_op   = alu_decode(funct3, funct7_alt);
            end
            rv_pkg::OPC_OP_IMM: begin
                alu_op = alu_decode(funct3, 1'b0);
            end
            rv_pkg::OPC_LUI: begin
                imm    = {fd_instr_i[31:12], 12'b0};
                alu_op = rv_pkg::ALU_PASS_B;
            end
            rv_pkg::OPC_LOAD: begin
                wb_sel = rv_pkg::WB_MEM;
            end
            rv_pkg::OPC_STORE: begin
                imm    = {{20{fd_instr_i[31]}}, fd_instr_i[31:25], fd_instr_i[11:7]};
                mem_we = 1'b1;
                wb_sel = rv_pkg::WB_NONE;
            end
            rv_pkg::OPC_BRANCH: begin
                imm    = {{20{fd_instr_i[31]}}, fd_instr_i[7], fd_instr_i[30:25],
                          fd_instr_i[11:8], 1'b0};
                branch = 1'b1;
                wb_sel = rv_pkg::WB_NONE;
                case (funct3)
                    3'b001:  cmp_op = rv_pkg::CMP_NE;
                    3'b100:  cmp_op = rv_pkg::CMP_LT;
                    default: cmp_op = rv_pkg::CMP_EQ;
                endcase
            end
            rv_pkg::OPC_JAL: begin
                imm    = {{12{fd_instr_i[31]}}, fd_instr_i[19:12], fd_instr_i[20],
                          fd_instr_i[30:21], 1'b0};
                jump   = 1'b1;
                wb_sel = rv_pkg::WB_PC_NEXT;
            end
            default: begin
                op_known = 1'b0;
            end
        endcase
    end

    // flushed or unknown instructions leave as bubbles
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            de_valid_o <= 1'b0;
        end else if (!hold_i) begin
            de_valid_o <= fd_valid_i && !flush_i && op_known;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            de_pc_o       <= fd_pc_i;
            de_rs1_o      <= rs1_o;
            de_rs2_o      <= rs2_o;
            de_rs1_data_o <= rs1_data_i;
            de_rs2_data_o <= rs2_data_i;
            de_imm_o      <= imm;
            de_rd_o       <= fd_instr_i[11:7];
            de_alu_op_o   <= alu_op;
            de_src2_sel_o <= src2_sel;
            de_cmp_op_o   <= cmp_op;
            de_branch_o   <= branch;
            de_jump_o     <= jump;
            de_mem_we_o   <= mem_we;
            de_wb_sel_o   <= wb_sel;
        end
    end

    a_known_opcode: assert property (@(posedge clk) disable iff (!arst_n_i)
        fd_valid_i && !flush_i && !hold_i |-> op_known)
        else $error("decode: unknown opcode %b at pc %h", opcode, fd_pc_i);

endmodule

// File: rtl/decode/rv_regfile.sv
module rv_regfile (
    input  logic              clk,
    input  logic              arst_n_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    output rv_pkg::data_t     rs1_data_o,
    output rv_pkg::data_t     rs2_data_o,
    input  logic              wb_en_i,
    input  rv_pkg::reg_addr_t wb_rd_i,
    input  rv_pkg::data_t     wb_data_i
);

    // x0 has no storage
    rv_pkg::data_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wb_en_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // same-cycle write is visible to decode at once
    always_comb begin
        if (rs1_i == '0) rs1_data_o = '0;
        else if (wb_en_i && wb_rd_i == rs1_i) rs1_data_o = wb_data_i;
        else rs1_data_o = regs[rs1_i];
        if (rs2_i == '0) rs2_data_o = '0;
        else if (wb_en_i && wb_rd_i == rs2_i) rs2_data_o = wb_data_i;
        else rs2_data_o = regs[rs2_i];
    end

    a_wb_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_en_i |-> !$isunknown(wb_rd_i) && !$isunknown(wb_data_i))
        else $error("regfile: write with unknown register or data");

endmodule

// File: rtl/execute/rv_execute.sv
module rv_execute (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              hold_i,
    input  logic              de_valid_i,
    input  rv_pkg::data_t     de_pc_i,
    input  rv_pkg::reg_addr_t de_rs1_i,
    input  rv_pkg::reg_addr_t de_rs2_i,
    input  rv_pkg::data_t     de_rs1_data_i,
    input  rv_pkg::data_t     de_rs2_data_i,
    input  rv_pkg::data_t     de_imm_i,
    input  rv_pkg::reg_addr_t de_rd_i,
    input  rv_pkg::alu_op_t   de_alu_op_i,
    input  rv_pkg::src2_sel_t de_src2_sel_i,
    input  rv_pkg::cmp_op_t   de_cmp_op_i,
    input  logic              de_branch_i,
    input  logic              de_jump_i,
    input  logic              de_mem_we_i,
    input  rv_pkg::wb_sel_t   de_wb_sel_i,
    input  logic              wb_en_i,
    input  rv_pkg::reg_addr_t wb_rd_i,
    input  rv_pkg::data_t     wb_data_i,
    output logic              redirect_o,
    output rv_pkg::data_t     target_o,
    output logic              er_valid_o,
    output logic              er_mem_we_o,
    output rv_pkg::data_t     er_alu_o,
    output rv_pkg::data_t     er_store_o,
    output rv_pkg::reg_addr_t er_rd_o,
    output rv_pkg::wb_sel_t   er_wb_sel_o,
    output rv_pkg::data_t     er_pc_next_o
);

    rv_pkg::data_t op_a;
    rv_pkg::data_t rs2_val;
    rv_pkg::data_t op_b;
    rv_pkg::data_t alu_res;
    logic          cmp_true;

    // bypass from result stage, load data included
    assign op_a    = (wb_en_i && wb_rd_i != '0 && wb_rd_i == de_rs1_i) ? wb_data_i
                                                                        : de_rs1_data_i;
    assign rs2_val = (wb_en_i && wb_rd_i != '0 && wb_rd_i == de_rs2_i) ? wb_data_i
                                                                        : de_rs2_data_i;
    assign op_b    = (de_src2_sel_i == rv_pkg::SRC2_IMM) ? de_imm_i : rs2_val;

    always_comb begin
        case (de_alu_op_i)
            rv_pkg::ALU_SUB: alu_res = op_a - op_b;
            rv_pkg::ALU_AND: alu_res = op_a & op_b;
            rv_pkg::ALU_OR:  alu_res = op_a | op_b;
            rv_pkg::ALU_XOR: alu_res = op_a ^ op_b;
            rv_pkg::ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLL: alu_res = op_a << op_b[4:0];
            rv_pkg::ALU_SRL: alu_res = op_a >> op_b[4:0];
            rv_pkg::ALU_PASS_B: alu_res = op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    // branches always compare two registers
    always_comb begin
        case (de_cmp_op_i)
            rv_pkg::CMP_NE: cmp_true = op_a != rs2_val;
            rv_pkg::CMP_LT: cmp_true = $signed(op_a) < $signed(rs2_val);
            default:        cmp_true = op_a == rs2_val;
        endcase
    end

    assign redirect_o = de_valid_i && (de_jump_i || (de_branch_i && cmp_true));
    assign target_o   = de_pc_i + de_imm_i;

    // branches leave as bubbles, jal carries its link write onward
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            er_valid_o <= 1'b0;
        end else if (!hold_i) begin
            er_valid_o <= de_valid_i && !de_branch_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            er_mem_we_o  <= de_mem_we_i;
            er_alu_o     <= alu_res;
            er_store_o   <= rs2_val;
            er_rd_o      <= de_rd_i;
            er_wb_sel_o  <= de_wb_sel_i;
            er_pc_next_o <= de_pc_i + 32'd4;
        end
    end

endmodule

// File: rtl/rv_result.sv
module rv_result (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              er_valid_i,
    input  logic              er_mem_we_i,
    input  rv_pkg::data_t     er_alu_i,
    input  rv_pkg::data_t     er_store_i,
    input  rv_pkg::reg_addr_t er_rd_i,
    input  rv_pkg::wb_sel_t   er_wb_sel_i,
    input  rv_pkg::data_t     er_pc_next_i,
    output logic              data_valid_o,
    output logic              data_we_o,
    output rv_pkg::data_t     data_addr_o,
    output rv_pkg::data_t     data_wdata_o,
    input  logic              data_ready_i,
    input  rv_pkg::data_t     data_rdata_i,
    output logic              hold_o,
    output logic              wb_en_o,
    output rv_pkg::reg_addr_t wb_rd_o,
    output rv_pkg::data_t     wb_data_o
);

    // loads and stores both go out on the data port
    assign data_valid_o = er_valid_i && (er_mem_we_i || er_wb_sel_i == rv_pkg::WB_MEM);
    assign data_we_o    = er_mem_we_i;
    assign data_addr_o  = er_alu_i;
    assign data_wdata_o = er_store_i;

    // freezes every stage until the request is taken
    assign hold_o = data_valid_o && !data_ready_i;

    assign wb_en_o = er_valid_i && er_wb_sel_i != rv_pkg::WB_NONE && !hold_o;
    assign wb_rd_o = er_rd_i;

    always_comb begin
        case (er_wb_sel_i)
            rv_pkg::WB_MEM:     wb_data_o = data_rdata_i;
            rv_pkg::WB_PC_NEXT: wb_data_o = er_pc_next_i;
            default:            wb_data_o = er_alu_i;
        endcase
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        data_valid_o && !data_ready_i |=> data_valid_o && $stable(data_we_o)
            && $stable(data_addr_o) && $stable(data_wdata_o))
        else $error("result: data request changed before acceptance");

endmodule

// File: rtl/rv_core.sv
module rv_core #(
    parameter rv_pkg::data_t BOOT_ADDR = '0
) (
    input  logic          clk,
    input  logic          arst_n_i,
    output rv_pkg::data_t instr_addr_o,
    input  rv_pkg::data_t instr_rdata_i,
    output logic          data_valid_o,
    output logic          data_we_o,
    output rv_pkg::data_t data_addr_o,
    output rv_pkg::data_t data_wdata_o,
    input  logic          data_ready_i,
    input  rv_pkg::data_t data_rdata_i
);

    logic              hold;
    logic              redirect;
    rv_pkg::data_t     target;

    logic              fd_valid;
    rv_pkg::data_t     fd_instr;
    rv_pkg::data_t     fd_pc;

    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::data_t     rs1_data;
    rv_pkg::data_t     rs2_data;

    logic              de_valid;
    rv_pkg::data_t     de_pc;
    rv_pkg::reg_addr_t de_rs1;
    rv_pkg::reg_addr_t de_rs2;
    rv_pkg::data_t     de_rs1_data;
    rv_pkg::data_t     de_rs2_data;
    rv_pkg::data_t     de_imm;
    rv_pkg::reg_addr_t de_rd;
    rv_pkg::alu_op_t   de_alu_op;
    rv_pkg::src2_sel_t de_src2_sel;
    rv_pkg::cmp_op_t   de_cmp_op;
    logic              de_branch;
    logic              de_jump;
    logic              de_mem_we;
    rv_pkg::wb_sel_t   de_wb_sel;

    logic              er_valid;
    logic              er_mem_we;
    rv_pkg::data_t     er_alu;
    rv_pkg::data_t     er_store;
    rv_pkg::reg_addr_t er_rd;
    rv_pkg::wb_sel_t   er_wb_sel;
    rv_pkg::data_t     er_pc_next;

    logic              wb_en;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::data_t     wb_data;

    rv_fetch #(
        .BOOT_ADDR(BOOT_ADDR)
    ) rv_fetch_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .hold_i       (hold),
        .redirect_i   (redirect),
        .target_i     (target),
        .instr_addr_o (instr_addr_o),
        .instr_rdata_i(instr_rdata_i),
        .fd_valid_o   (fd_valid),
        .fd_instr_o   (fd_instr),
        .fd_pc_o      (fd_pc)
    );

    // the redirect doubles as the decode flush
    rv_decode rv_decode_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .hold_i       (hold),
        .flush_i      (redirect),
        .fd_valid_i   (fd_valid),
        .fd_instr_i   (fd_instr),
        .fd_pc_i      (fd_pc),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .de_valid_o   (de_valid),
        .de_pc_o      (de_pc),
        .de_rs1_o     (de_rs1),
        .de_rs2_o     (de_rs2),
        .de_rs1_data_o(de_rs1_data),
        .de_rs2_data_o(de_rs2_data),
        .de_imm_o     (de_imm),
        .de_rd_o      (de_rd),
        .de_alu_op_o  (de_alu_op),
        .de_src2_sel_o(de_src2_sel),
        .de_cmp_op_o  (de_cmp_op),
        .de_branch_o  (de_branch),
        .de_jump_o    (de_jump),
        .de_mem_we_o  (de_mem_we),
        .de_wb_sel_o  (de_wb_sel)
    );

    rv_regfile rv_regfile_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .wb_en_i   (wb_en),
        .wb_rd_i   (wb_rd),
        .wb_data_i (wb_data)
    );

    rv_execute rv_execute_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .hold_i       (hold),
        .de_valid_i   (de_valid),
        .de_pc_i      (de_pc),
        .de_rs1_i     (de_rs1),
        .de_rs2_i     (de_rs2),
        .de_rs1_data_i(de_rs1_data),
        .de_rs2_data_i(de_rs2_data),
        .de_imm_i     (de_imm),
        .de_rd_i      (de_rd),
        .de_alu_op_i  (de_alu_op),
        .de_src2_sel_i(de_src2_sel),
        .de_cmp_op_i  (de_cmp_op),
        .de_branch_i  (de_branch),
        .de_jump_i    (de_jump),
        .de_mem_we_i  (de_mem_we),
        .de_wb_sel_i  (de_wb_sel),
        .wb_en_i      (wb_en),
        .wb_rd_i      (wb_rd),
        .wb_data_i    (wb_data),
        .redirect_o   (redirect),
        .target_o     (target),
        .er_valid_o   (er_valid),
        .er_mem_we_o  (er_mem_we),
        .er_alu_o     (er_alu),
        .er_store_o   (er_store),
        .er_rd_o      (er_rd),
        .er_wb_sel_o  (er_wb_sel),
        .er_pc_next_o (er_pc_next)
    );

    rv_result rv_result_i (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .er_valid_i  (er_valid),
        .er_mem_we_i (er_mem_we),
        .er_alu_i    (er_alu),
        .er_store_i  (er_store),
        .er_rd_i     (er_rd),
        .er_wb_sel_i (er_wb_sel),
        .er_pc_next_i(er_pc_next),
        .data_valid_o(data_valid_o),
        .data_we_o   (data_we_o),
        .data_addr_o (data_addr_o),
        .data_wdata_o(data_wdata_o),
        .data_ready_i(data_ready_i),
        .data_rdata_i(data_rdata_i),
        .hold_o      (hold),
        .wb_en_o     (wb_en),
        .wb_rd_o     (wb_rd),
        .wb_data_o   (wb_data)
    );

endmodule

// File: tests/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN   = 68;
localparam int NUM_STORES = 24;
localparam int NUM_TESTS  = 4;
localparam logic [31:0] POISON_ADDR = 32'h0000_03fc;
localparam logic [31:0] DONE_ADDR   = 32'h0000_03f0;
localparam logic [31:0] NOP_WORD    = 32'h0000_0013;

logic [31:0] rom [PROG_LEN];
logic [31:0] exp_addr [NUM_STORES];
logic [31:0] exp_data [NUM_STORES];
int          test_last [NUM_TESTS];
string       test_name [NUM_TESTS];

// RV32I instruction formats
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input rv_pkg::opcode_t opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

// sw only
function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] upper, input logic [4:0] rd);
    return {upper, rd, rv_pkg::OPC_LUI};
endfunction

task automatic expect_store(input int idx, input logic [31:0] addr, input logic [31:0] data);
    exp_addr[idx] = addr;
    exp_data[idx] = data;
endtask

task automatic load_program();
    // alu and lui, x1 = 5, x2 = -3, x10 = 0x100
    rom[0]  = enc_i(5, 0, 3'b000, 1, rv_pkg::OPC_OP_IMM);
    rom[1]  = enc_i(-3, 0, 3'b000, 2, rv_pkg::OPC_OP_IMM);
    rom[2]  = enc_i(32'h100, 0, 3'b000, 10, rv_pkg::OPC_OP_IMM);
    rom[3]  = enc_r(7'h00, 2, 1, 3'b000, 3);
    rom[4]  = enc_r(7'h20, 2, 1, 3'b000, 4);
    rom[5]  = enc_r(7'h00, 2, 1, 3'b111, 5);
    rom[6]  = enc_r(7'h00, 2, 1, 3'b110, 6);
    rom[7]  = enc_r(7'h00, 2, 1, 3'b100, 7);
    rom[8]  = enc_r(7'h00, 1, 2, 3'b010, 8);
    rom[9]  = enc_r(7'h00, 1, 1, 3'b001, 9);
    rom[10] = enc_r(7'h00, 1, 2, 3'b101, 11);
    rom[11] = enc_s(0, 3, 10);
    rom[12] = enc_s(4, 4, 10);
    rom[13] = enc_s(8, 5, 10);
    rom[14] = enc_s(12, 6, 10);
    rom[15] = enc_s(16, 7, 10);
    rom[16] = enc_s(20, 8, 10);
    rom[17] = enc_s(24, 9, 10);
    rom[18] = enc_s(28, 11, 10);
    rom[19] = enc_u(20'h12345, 12);
    rom[20] = enc_i(32'h0ff, 12, 3'b100, 13, rv_pkg::OPC_OP_IMM);
    rom[21] = enc_i(32'h030, 1, 3'b110, 14, rv_pkg::OPC_OP_IMM);
    rom[22] = enc_i(32'h07f, 2, 3'b111, 15, rv_pkg::OPC_OP_IMM);
    rom[23] = enc_i(-2, 2, 3'b010, 16, rv_pkg::OPC_OP_IMM);
    rom[24] = enc_i(4, 1, 3'b001, 17, rv_pkg::OPC_OP_IMM);
    rom[25] = enc_i(28, 2, 3'b101, 18, rv_pkg::OPC_OP_IMM);
    rom[26] = enc_s(32, 12, 10);
    rom[27] = enc_s(36, 13, 10);
    rom[28] = enc_s(40, 14, 10);
    rom[29] = enc_s(44, 15, 10);
    rom[30] = enc_s(48, 16, 10);
    rom[31] = enc_s(52, 17, 10);
    rom[32] = enc_s(56, 18, 10);
    // dependent pairs at distance 1, 2 and 3, then load-use
    rom[33] = enc_i(32'h200, 0, 3'b000, 20, rv_pkg::OPC_OP_IMM);
    rom[34] = enc_i(7, 0, 3'b000, 21, rv_pkg::OPC_OP_IMM);
    rom[35] = enc_r(7'h00, 21, 21, 3'b000, 22);
    rom[36] = enc_r(7'h00, 21, 22, 3'b000, 23);
    rom[37] = enc_r(7'h00, 23, 21, 3'b000, 24);
    rom[38] = enc_s(0, 24, 20);
    rom[39] = enc_s(4, 23, 20);
    rom[40] = enc_i(0, 20, 3'b010, 25, rv_pkg::OPC_LOAD);
    rom[41] = enc_i(1, 25, 3'b000, 26, rv_pkg::OPC_OP_IMM);
    rom[42] = enc_s(8, 26, 20);
    rom[43] = enc_i(4, 20, 3'b010, 27, rv_pkg::OPC_LOAD);
    rom[44] = enc_s(12, 27, 20);
    // branches, a poison store follows each taken one
    rom[45] = enc_i(32'h300, 0, 3'b000, 30, rv_pkg::OPC_OP_IMM);
    rom[46] = enc_i(POISON_ADDR, 0, 3'b000, 29, rv_pkg::OPC_OP_IMM);
    rom[47] = enc_i(3, 0, 3'b000, 5, rv_pkg::OPC_OP_IMM);
    rom[48] = enc_i(3, 0, 3'b000, 6, rv_pkg::OPC_OP_IMM);
    rom[49] = enc_b(8, 6, 5, 3'b000);
    rom[50] = enc_s(0, 0, 29);
    rom[51] = enc_i(32'h011, 0, 3'b000, 7, rv_pkg::OPC_OP_IMM);
    rom[52] = enc_b(8, 6, 5, 3'b001);
    rom[53] = enc_s(0, 7, 30);
    rom[54] = enc_b(8, 1, 5, 3'b001);
    rom[55] = enc_s(0, 0, 29);
    rom[56] = enc_b(8, 5, 2, 3'b100);
    rom[57] = enc_s(0, 0, 29);
    rom[58] = enc_b(8, 2, 5, 3'b100);
    rom[59] = enc_s(4, 5, 30);
    rom[60] = enc_b(8, 1, 5, 3'b000);
    rom[61] = enc_s(8, 1, 30);
    rom[62] = enc_j(8, 31);
    rom[63] = enc_s(0, 0, 29);
    rom[64] = enc_s(12, 31, 30);
    // final store, then spin in place
    rom[65] = enc_i(1, 0, 3'b000, 19, rv_pkg::OPC_OP_IMM);
    rom[66] = enc_s(DONE_ADDR, 19, 0);
    rom[67] = enc_j(0, 0);

    expect_store(0, 32'h100, 32'h0000_0002);
    expect_store(1, 32'h104, 32'h0000_0008);
    expect_store(2, 32'h108, 32'h0000_0005);
    expect_store(3, 32'h10c, 32'hffff_fffd);
    expect_store(4, 32'h110, 32'hffff_fff8);
    expect_store(5, 32'h114, 32'h0000_0001);
    expect_store(6, 32'h118, 32'h0000_00a0);
    expect_store(7, 32'h11c, 32'h07ff_ffff);
    expect_store(8, 32'h120, 32'h1234_5000);
    expect_store(9, 32'h124, 32'h1234_50ff);
    expect_store(10, 32'h128, 32'h0000_0035);
    expect_store(11, 32'h12c, 32'h0000_007d);
    expect_store(12, 32'h130, 32'h0000_0001);
    expect_store(13, 32'h134, 32'h0000_0050);
    expect_store(14, 32'h138, 32'h0000_000f);
    expect_store(15, 32'h200, 32'h0000_001c);
    expect_store(16, 32'h204, 32'h0000_0015);
    expect_store(17, 32'h208, 32'h0000_001d);
    expect_store(18, 32'h20c, 32'h0000_0015);
    expect_store(19, 32'h300, 32'h0000_0011);
    expect_store(20, 32'h304, 32'h0000_0003);
    expect_store(21, 32'h308, 32'h0000_0005);
    // link of the jal at 0xf8
    expect_store(22, 32'h30c, 32'h0000_00fc);
    expect_store(23, DONE_ADDR, 32'h0000_0001);

    test_name[0] = "alu and lui";
    test_last[0] = 14;
    test_name[1] = "forwarding and load-use";
    test_last[1] = 18;
    test_name[2] = "branches and jal";
    test_last[2] = 22;
    test_name[3] = "done store";
    test_last[3] = 23;
endtask

`endif

// File: tests/tb_rv_core.sv
module tb_rv_core;

    timeunit 1ns;
    timeprecision 100ps;

    `include "tb_program.svh"

    localparam int RESET_CYCLES = 16;
    localparam int CYCLE_LIMIT  = PROG_LEN * 8 + RESET_CYCLES;
    localparam logic [31:0] BOOT_ADDR = 32'h0;
    localparam logic [31:0] LFSR_SEED = 32'hc1c1;

    logic          clk = 1'b0;
    logic          arst_n;
    rv_pkg::data_t instr_addr;
    rv_pkg::data_t instr_rdata;
    logic          data_valid;
    logic          data_we;
    rv_pkg::data_t data_addr;
    rv_pkg::data_t data_wdata;
    logic          data_ready;
    rv_pkg::data_t data_rdata;

    logic [31:0] dmem [256];
    logic [31:0] lfsr;
    int          store_idx;
    int          fail_count;
    int          cycle_count;
    int          next_test;
    int          fails_at_test_start;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    always #50 clk = ~clk;

    rv_core #(
        .BOOT_ADDR(BOOT_ADDR)
    ) rv_core_i (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .instr_addr_o (instr_addr),
        .instr_rdata_i(instr_rdata),
        .data_valid_o (data_valid),
        .data_we_o    (data_we),
        .data_addr_o  (data_addr),
        .data_wdata_o (data_wdata),
        .data_ready_i (data_ready),
        .data_rdata_i (data_rdata)
    );

    // both memories answer in the same cycle
    assign instr_rdata = (instr_addr[31:2] < PROG_LEN) ? rom[instr_addr[31:2]] : NOP_WORD;
    assign data_rdata  = dmem[data_addr[9:2]];

    always @(negedge clk) begin
        lfsr = lfsr_step(lfsr);
        data_ready <= lfsr[0];
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (arst_n && data_valid && data_ready && data_we) begin
            dmem[data_addr[9:2]] <= data_wdata;
            store_idx <= store_idx + 1;
        end
    end

    // one line per test once its last store went through
    always @(negedge clk) begin
        if (next_test < NUM_TESTS && store_idx > test_last[next_test]) begin
            $display("test %0d (%s): %s", next_test, test_name[next_test],
                     fail_count == fails_at_test_start ? "ok" : "errors seen");
            fails_at_test_start = fail_count;
            next_test = next_test + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        $past(!arst_n) |-> !data_valid && instr_addr == BOOT_ADDR)
        else begin
            $display("CHECK FAILED at %0t: reset state valid=%b pc=%h", $time,
                     $sampled(data_valid), $sampled(instr_addr));
            fail_count++;
        end

    a_store_order: assert property (@(posedge clk) disable iff (!arst_n)
        data_valid && data_ready && data_we |-> store_idx < NUM_STORES
            && data_addr == exp_addr[store_idx] && data_wdata == exp_data[store_idx])
        else begin
            $display("CHECK FAILED at %0t: store %0d wrote %h to %h", $time,
                     $sampled(store_idx), $sampled(data_wdata), $sampled(data_addr));
            fail_count++;
        end

    a_no_poison: assert property (@(posedge clk) disable iff (!arst_n)
        data_valid && data_we |-> data_addr != POISON_ADDR)
        else begin
            $display("CHECK FAILED at %0t: store on a wrong branch path reached %h",
                     $time, $sampled(data_addr));
            fail_count++;
        end

    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        data_valid && !data_ready |=> data_valid && $stable(data_addr)
            && $stable(data_we) && $stable(data_wdata))
        else begin
            $display("CHECK FAILED at %0t: request changed before acceptance, addr %h",
                     $time, $sampled(data_addr));
            fail_count++;
        end

    initial begin
        arst_n = 1'b0;
        data_ready = 1'b0;
        lfsr = LFSR_SEED;
        store_idx = 0;
        fail_count = 0;
        cycle_count = 0;
        next_test = 0;
        fails_at_test_start = 0;
        load_program();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'h5a5a_0000 ^ (i << 2);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        while (store_idx < NUM_STORES && cycle_count < CYCLE_LIMIT) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (store_idx < NUM_STORES) begin
            $display("timeout: the program never reached its final store after %0d cycles",
                     cycle_count);
        end
        $display("tests done %0d of %0d, stores %0d of %0d, failed checks %0d",
                 next_test, NUM_TESTS, store_idx, NUM_STORES, fail_count);
        if (fail_count == 0 && store_idx == NUM_STORES) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+tests
common/rv_pkg.sv
rtl/rv_fetch.sv
rtl/decode/rv_decode.sv
rtl/decode/rv_regfile.sv
rtl/execute/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core.sv
tests/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - common/rv_pkg.sv
      - rtl/rv_fetch.sv
      - rtl/decode/rv_decode.sv
      - rtl/decode/rv_regfile.sv
      - rtl/execute/rv_execute.sv
      - rtl/rv_result.sv
      - rtl/rv_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv_core.sv
